/* design/i2c_bit_timing.sv */
`timescale 1ns/1ns

module i2c_bit_timing import i2c_pkg::*; (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     run,
    input  logic [DIVIDER_WIDTH-1:0] divider,
    input  i2c_drive_t               bus_drive,
    input  i2c_sense_t               bus_sense,
    output logic                     step,
    output i2c_phase_t               phase,
    output logic                     stretch_timeout
);

    logic [DIVIDER_WIDTH-1:0]       divider_count;
    logic [STRETCH_COUNT_WIDTH-1:0] stretch_count;
    logic                           tick;
    logic                           stretching;
    logic                           stretch_limit;

    ////////////////////
    // Tick and phase strobes

    // One tick every divider+1 cycles
    assign tick = run && (divider_count >= divider);

    // Master let SCL go but a target still holds it low
    assign stretching = (phase == PH_RISE) && !bus_drive.scl_low && !bus_sense.scl;

    assign stretch_limit = (stretch_count == STRETCH_COUNT_WIDTH'(STRETCH_MAX_TICKS - 1));

    assign step = tick && !stretching;                           // Phase advances only here

    ////////////////////
    // Counters

    always_ff @(posedge clock) begin
        if (!reset_n || !run) begin
            divider_count   <= '0;
            stretch_count   <= '0;
            phase           <= PH_SETUP;                         // Every transaction starts a slot
            stretch_timeout <= 1'b0;
        end else begin
            stretch_timeout <= 1'b0;
            if (tick) begin
                divider_count <= '0;
                if (stretching) begin
                    // Hold in PH_RISE and count the wait
                    if (stretch_limit) begin
                        stretch_timeout <= 1'b1;
                        stretch_count   <= '0;
                    end else begin
                        stretch_count <= stretch_count + 1'b1;
                    end
                end else begin
                    stretch_count <= '0;
                    phase         <= i2c_phase_t'(phase + 2'd1);  // Wraps PH_FALL to PH_SETUP
                end
            end else begin
                divider_count <= divider_count + 1'b1;
            end
        end
    end

    ////////////////////
    // Checks

    // The registered pulse must still find the slot parked in PH_RISE
    assert property (@(posedge clock) disable iff (!reset_n)
        stretch_timeout |-> (phase == PH_RISE))
        else $error("stretch_timeout fired outside PH_RISE");

endmodule

/* design/i2c_byte_shifter.sv */
`timescale 1ns/1ns

module i2c_byte_shifter import i2c_pkg::*; (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  load,
    input  logic [BYTE_WIDTH-1:0] load_byte,
    input  logic                  shift_enable,
    input  logic                  step,
    input  i2c_phase_t            phase,
    input  logic                  sda,
    output logic                  tx_bit,
    output logic                  sampled_bit,
    output logic [BYTE_WIDTH-1:0] rx_byte,
    output logic                  slot_done
);

    logic [BYTE_WIDTH:0]        tx_shift;                        // Byte followed by the ACK bit
    logic [BIT_COUNT_WIDTH-1:0] bit_count;
    logic                       sample_step;
    logic                       present_step;

    assign sample_step  = shift_enable && step && (phase == PH_HIGH);
    assign present_step = shift_enable && step && (phase == PH_FALL);

    assign tx_bit = tx_shift[BYTE_WIDTH];                        // MSB first

    // Ninth bit just sampled, ACK or NACK lands in sampled_bit
    assign slot_done = sample_step && (bit_count == BIT_COUNT_WIDTH'(BITS_PER_GROUP - 1));

    ////////////////////
    // Bit counter

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            bit_count <= '0;
        end else if (load) begin
            bit_count <= '0;
        end else if (sample_step) begin
            bit_count <= bit_count + 1'b1;
        end
    end

    ////////////////////
    // Shift paths

    always_ff @(posedge clock) begin
        if (load) begin
            tx_shift <= {load_byte, 1'b1};                       // ACK slot left released
        end else if (present_step) begin
            tx_shift <= {tx_shift[BYTE_WIDTH-1:0], 1'b1};
        end

        if (sample_step) begin
            sampled_bit <= sda;
            // Only the eight data bits go into the receive byte
            if (bit_count < BIT_COUNT_WIDTH'(BYTE_WIDTH)) begin
                rx_byte <= {rx_byte[BYTE_WIDTH-2:0], sda};
            end
        end
    end

    // Loading mid-byte would corrupt the bit count, the FSM loads only between groups
    assert property (@(posedge clock) disable iff (!reset_n)
        !(load && shift_enable))
        else $error("load and shift_enable asserted together");

endmodule

/* design/i2c_master_top.sv */
`timescale 1ns/1ns

module i2c_master_top import i2c_pkg::*; (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     enable,
    input  i2c_request_t             request,
    input  logic [DIVIDER_WIDTH-1:0] divider,
    output logic                     busy,
    output logic [BYTE_WIDTH-1:0]    read_data,
    output logic                     error,
    output i2c_drive_t               bus_drive,
    input  i2c_sense_t               bus_sense
);

    logic                  step;
    i2c_phase_t            phase;
    logic                  stretch_timeout;
    logic                  run;
    logic                  load;
    logic [BYTE_WIDTH-1:0] load_byte;
    logic                  shift_enable;
    logic                  tx_bit;
    logic                  sampled_bit;
    logic [BYTE_WIDTH-1:0] rx_byte;
    logic                  slot_done;

    // Slot timing, watches its own SCL drive for stretching
    i2c_bit_timing i_bit_timing (
        .clock           (clock),
        .reset_n         (reset_n),
        .run             (run),
        .divider         (divider),
        .bus_drive       (bus_drive),
        .bus_sense       (bus_sense),
        .step            (step),
        .phase           (phase),
        .stretch_timeout (stretch_timeout)
    );

    i2c_byte_shifter i_byte_shifter (
        .clock        (clock),
        .reset_n      (reset_n),
        .load         (load),
        .load_byte    (load_byte),
        .shift_enable (shift_enable),
        .step         (step),
        .phase        (phase),
        .sda          (bus_sense.sda),
        .tx_bit       (tx_bit),
        .sampled_bit  (sampled_bit),
        .rx_byte      (rx_byte),
        .slot_done    (slot_done)
    );

    i2c_transaction_fsm i_transaction_fsm (
        .clock           (clock),
        .reset_n         (reset_n),
        .enable          (enable),
        .request         (request),
        .step            (step),
        .phase           (phase),
        .stretch_timeout (stretch_timeout),
        .tx_bit          (tx_bit),
        .sampled_bit     (sampled_bit),
        .rx_byte         (rx_byte),
        .slot_done       (slot_done),
        .run             (run),
        .load            (load),
        .load_byte       (load_byte),
        .shift_enable    (shift_enable),
        .bus_drive       (bus_drive),
        .busy            (busy),
        .read_data       (read_data),
        .error           (error)
    );

endmodule

/* design/i2c_pkg.sv */
package i2c_pkg;

    ////////////////////
    // Field and bus widths

    localparam int ADDRESS_WIDTH       = 7;                      // 7-bit device address
    localparam int BYTE_WIDTH          = 8;                      // Register address and data
    localparam int DIVIDER_WIDTH       = 16;
    localparam int BITS_PER_GROUP      = BYTE_WIDTH + 1;         // Eight data bits plus ACK
    localparam int BIT_COUNT_WIDTH     = $clog2(BITS_PER_GROUP + 1);

    // Divider ticks allowed for SCL to come high in the rise phase
    localparam int STRETCH_MAX_TICKS   = 255;
    localparam int STRETCH_COUNT_WIDTH = $clog2(STRETCH_MAX_TICKS + 1);

    ////////////////////
    // Transaction states

    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        START      = 4'd1,
        ADDR_W     = 4'd2,
        REG_ADDR   = 4'd3,
        RESTART    = 4'd4,
        ADDR_R     = 4'd5,
        WRITE_DATA = 4'd6,
        READ_DATA  = 4'd7,
        CHECK_ACK  = 4'd8,                                       // Tail of a slave ACK bit
        SEND_NACK  = 4'd9,                                       // Tail of the master NACK bit
        STOP       = 4'd10
    } i2c_state_t;

    // Four phases of every bit slot
    typedef enum logic [1:0] {
        PH_SETUP = 2'd0,                                         // SCL low, SDA settles
        PH_RISE  = 2'd1,                                         // SCL released, may stretch
        PH_HIGH  = 2'd2,                                         // SCL high, SDA sampled on exit
        PH_FALL  = 2'd3                                          // SCL pulled low again
    } i2c_phase_t;

    ////////////////////
    // Host request and bus lines

    typedef struct packed {
        logic                     read_write;                    // 1 for a register read
        logic [ADDRESS_WIDTH-1:0] device_address;
        logic [BYTE_WIDTH-1:0]    register_address;
        logic [BYTE_WIDTH-1:0]    write_data;
    } i2c_request_t;

    // Open-drain drive, a set bit pulls the line low
    typedef struct packed {
        logic scl_low;
        logic sda_low;
    } i2c_drive_t;

    // Line levels as seen on the wired-AND bus
    typedef struct packed {
        logic scl;
        logic sda;
    } i2c_sense_t;

endpackage

/* design/i2c_transaction_fsm.sv */
`timescale 1ns/1ns

module i2c_transaction_fsm import i2c_pkg::*; (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  enable,
    input  i2c_request_t          request,
    input  logic                  step,
    input  i2c_phase_t            phase,
    input  logic                  stretch_timeout,
    input  logic                  tx_bit,
    input  logic                  sampled_bit,
    input  logic [BYTE_WIDTH-1:0] rx_byte,
    input  logic                  slot_done,
    output logic                  run,
    output logic                  load,
    output logic [BYTE_WIDTH-1:0] load_byte,
    output logic                  shift_enable,
    output i2c_drive_t            bus_drive,
    output logic                  busy,
    output logic [BYTE_WIDTH-1:0] read_data,
    output logic                  error
);

    i2c_state_t   state;
    i2c_state_t   state_next;
    i2c_state_t   after_ack;                                     // Where a good ACK leads
    i2c_state_t   after_ack_next;
    i2c_request_t saved_request;
    logic         accept;
    logic         capture_read;
    logic         set_error;
    logic         fall_step;
    logic         byte_state;

    assign fall_step = step && (phase == PH_FALL);               // Last step of a slot

    assign byte_state = (state == ADDR_W) || (state == REG_ADDR) || (state == ADDR_R)
                     || (state == WRITE_DATA) || (state == READ_DATA);

    assign run          = (state != IDLE);
    assign busy         = (state != IDLE);
    assign shift_enable = byte_state;

    ////////////////////
    // Next state

    always_comb begin
        state_next     = state;
        after_ack_next = after_ack;
        load           = 1'b0;
        load_byte      = '1;                                     // Released bits for a read
        accept         = 1'b0;
        capture_read   = 1'b0;
        set_error      = 1'b0;

        case (state)
            IDLE: begin
                if (enable) begin
                    accept     = 1'b1;
                    state_next = START;
                end
            end
            START: begin
                if (fall_step) begin
                    load       = 1'b1;
                    load_byte  = {saved_request.device_address, 1'b0};  // Write direction
                    state_next = ADDR_W;
                end
            end
            RESTART: begin
                if (fall_step) begin
                    load       = 1'b1;
                    load_byte  = {saved_request.device_address, 1'b1};  // Read direction
                    state_next = ADDR_R;
                end
            end
            ADDR_W: begin
                if (slot_done) begin
                    after_ack_next = REG_ADDR;
                    state_next     = CHECK_ACK;
                end
            end
            REG_ADDR: begin
                if (slot_done) begin
                    after_ack_next = saved_request.read_write ? RESTART : WRITE_DATA;
                    state_next     = CHECK_ACK;
                end
            end
            ADDR_R: begin
                if (slot_done) begin
                    after_ack_next = READ_DATA;
                    state_next     = CHECK_ACK;
                end
            end
            WRITE_DATA: begin
                if (slot_done) begin
                    after_ack_next = STOP;
                    state_next     = CHECK_ACK;
                end
            end
            READ_DATA: begin
                if (slot_done) begin
                    capture_read = 1'b1;                         // All eight data bits are in
                    state_next   = SEND_NACK;
                end
            end
            CHECK_ACK: begin
                if (fall_step) begin
                    if (sampled_bit) begin
                        set_error  = 1'b1;                       // Target did not answer
                        state_next = STOP;
                    end else begin
                        state_next = after_ack;
                        case (after_ack)
                            REG_ADDR: begin
                                load      = 1'b1;
                                load_byte = saved_request.register_address;
                            end
                            WRITE_DATA: begin
                                load      = 1'b1;
                                load_byte = saved_request.write_data;
                            end
                            READ_DATA: load = 1'b1;
                            default: ;
                        endcase
                    end
                end
            end
            SEND_NACK: begin
                if (fall_step) state_next = STOP;
            end
            STOP: begin
                if (fall_step) state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase

        // Stuck clock abandons the transfer without a STOP
        if (stretch_timeout && (state != IDLE)) begin
            set_error  = 1'b1;
            state_next = IDLE;
        end
    end

    ////////////////////
    // Registers

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state     <= IDLE;
            after_ack <= IDLE;
            read_data <= '0;
            error     <= 1'b0;
        end else begin
            state     <= state_next;
            after_ack <= after_ack_next;
            if (accept) begin
                error <= 1'b0;
            end else if (set_error) begin
                error <= 1'b1;
            end
            if (capture_read) read_data <= rx_byte;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) saved_request <= request;
    end

    ////////////////////
    // Line drive per state and phase

    always_comb begin
        bus_drive = '0;
        case (state)
            START, RESTART: begin
                // SDA falls while SCL is high
                bus_drive.scl_low = (phase == PH_FALL) || ((state == RESTART) && (phase == PH_SETUP));
                bus_drive.sda_low = (phase == PH_HIGH) || (phase == PH_FALL);
            end
            ADDR_W, REG_ADDR, ADDR_R, WRITE_DATA, READ_DATA: begin
                bus_drive.scl_low = (phase == PH_SETUP) || (phase == PH_FALL);
                bus_drive.sda_low = !tx_bit;
            end
            CHECK_ACK, SEND_NACK: bus_drive.scl_low = 1'b1;      // Only live during PH_FALL
            STOP: begin
                // SDA rises while SCL is high
                bus_drive.scl_low = (phase == PH_SETUP);
                bus_drive.sda_low = (phase != PH_FALL);
            end
            default: ;
        endcase
    end

    // Data may only move under a released clock as a START, RESTART or STOP,
    // or when a stretch timeout drops the lines
    assert property (@(posedge clock) disable iff (!reset_n)
        (!bus_drive.scl_low && !$past(bus_drive.scl_low)
            && (bus_drive.sda_low != $past(bus_drive.sda_low)))
        |-> ((state inside {START, RESTART, STOP}) || $past(stretch_timeout)))
        else $error("SDA changed while SCL released");

endmodule

/* run.sh */
#!/bin/sh
# Build and run the I2C master testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_i2c_master -f src.f -o sim_i2c_master &&
./obj_dir/sim_i2c_master || { echo "Simulation did not pass"; exit 1; }

/* src.f */
design/i2c_pkg.sv
design/i2c_bit_timing.sv
design/i2c_byte_shifter.sv
design/i2c_transaction_fsm.sv
design/i2c_master_top.sv
verif/i2c_target_model.sv
verif/tb_i2c_master.sv

/* verif/i2c_target_model.sv */
`timescale 1ns/1ns

module i2c_target_model import i2c_pkg::*; (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic [ADDRESS_WIDTH-1:0] device_address,
    input  logic [15:0]              stretch_ticks,   // 0 turns stretching off
    input  logic [DIVIDER_WIDTH-1:0] divider,
    input  i2c_sense_t               bus_sense,
    output i2c_drive_t               bus_drive,
    output i2c_request_t             captured,
    output logic                     stop_seen
);

    typedef enum logic [2:0] {
        T_IDLE,
        T_RECEIVE,
        T_ACK,
        T_SEND,
        T_MASTER_ACK
    } target_state_t;

    target_state_t         state;
    logic                  scl_prev;
    logic                  sda_prev;
    logic                  start_cond;
    logic                  stop_cond;
    logic                  scl_rise;
    logic                  scl_fall;
    logic [3:0]            bit_count;
    logic [1:0]            byte_index;                           // 0 address, 1 register, 2 data
    logic                  read_mode;
    logic [BYTE_WIDTH-1:0] shift;
    logic [BYTE_WIDTH-1:0] send_byte;
    logic [BYTE_WIDTH-1:0] current_register;
    logic [BYTE_WIDTH-1:0] read_value;
    logic [31:0]           stretch_left;
    logic [BYTE_WIDTH-1:0] registers [256];
    logic [255:0]          written;

    assign start_cond = bus_sense.scl && scl_prev && sda_prev && !bus_sense.sda;
    assign stop_cond  = bus_sense.scl && scl_prev && !sda_prev && bus_sense.sda;
    assign scl_rise   = bus_sense.scl && !scl_prev;
    assign scl_fall   = !bus_sense.scl && scl_prev;

    // Unwritten registers read back as their address XOR A5
    assign read_value = written[current_register] ? registers[current_register]
                                                  : (current_register ^ 8'hA5);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state            <= T_IDLE;
            scl_prev         <= 1'b1;
            sda_prev         <= 1'b1;
            bus_drive        <= '0;
            captured         <= '0;
            stop_seen        <= 1'b0;
            bit_count        <= '0;
            byte_index       <= '0;
            read_mode        <= 1'b0;
            shift            <= '0;
            send_byte        <= '0;
            current_register <= '0;
            stretch_left     <= '0;
            written          <= '0;
        end else begin
            scl_prev  <= bus_sense.scl;
            sda_prev  <= bus_sense.sda;
            stop_seen <= 1'b0;
            if (stretch_left != 32'd0) begin
                stretch_left <= stretch_left - 32'd1;
                if (stretch_left == 32'd1) bus_drive.scl_low <= 1'b0;
            end
            if (start_cond) begin                                // START or repeated START
                state             <= T_RECEIVE;
                bit_count         <= '0;
                byte_index        <= '0;
                bus_drive.sda_low <= 1'b0;
            end else if (stop_cond) begin
                state             <= T_IDLE;
                stop_seen         <= 1'b1;
                bus_drive.sda_low <= 1'b0;
            end else if (scl_rise && (state == T_RECEIVE || state == T_SEND)) begin
                shift     <= {shift[BYTE_WIDTH-2:0], bus_sense.sda};
                bit_count <= bit_count + 4'd1;
            end else if (scl_fall) begin
                case (state)
                    T_RECEIVE: begin
                        if (bit_count == 4'd8) begin
                            bit_count <= '0;
                            state     <= T_ACK;
                            bus_drive.sda_low <= 1'b1;
                            if (byte_index == 2'd0) begin
                                captured.device_address <= shift[7:1];
                                captured.read_write     <= shift[0];
                                read_mode               <= shift[0];
                                if (shift[7:1] != device_address) begin
                                    state             <= T_IDLE;   // Not ours, no ACK
                                    bus_drive.sda_low <= 1'b0;
                                end
                            end else if (byte_index == 2'd1) begin
                                current_register          <= shift;
                                captured.register_address <= shift;
                            end else begin
                                captured.write_data         <= shift;
                                registers[current_register] <= shift;
                                written[current_register]   <= 1'b1;
                            end
                        end
                    end
                    T_ACK: begin
                        bit_count <= '0;
                        if (read_mode) begin
                            send_byte         <= read_value;
                            bus_drive.sda_low <= !read_value[BYTE_WIDTH-1];
                            state             <= T_SEND;
                        end else begin
                            bus_drive.sda_low <= 1'b0;
                            byte_index        <= byte_index + 2'd1;
                            state             <= T_RECEIVE;
                            // Hold SCL once, after the write address is acknowledged
                            if (byte_index == 2'd0 && stretch_ticks != 16'd0) begin
                                bus_drive.scl_low <= 1'b1;
                                stretch_left <= 32'(stretch_ticks) * (32'(divider) + 32'd1);
                            end
                        end
                    end
                    T_SEND: begin
                        if (bit_count == 4'd8) begin
                            bus_drive.sda_low <= 1'b0;           // Master answers with NACK
                            state             <= T_MASTER_ACK;
                        end else begin
                            bus_drive.sda_low <= !send_byte[BYTE_WIDTH-2];
                            send_byte         <= {send_byte[BYTE_WIDTH-2:0], 1'b0};
                        end
                    end
                    T_MASTER_ACK: state <= T_IDLE;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* verif/tb_i2c_master.sv */
`timescale 1ns/1ns

module tb_i2c_master import i2c_pkg::*; ();

    localparam int          HALF_PERIOD  = 20;                   // 40 ns clock
    localparam int          RESET_CYCLES = 4;
    localparam int          CYCLE_LIMIT  = 20000;
    localparam logic [15:0] LFSR_SEED    = 16'd86;

    logic                     clock = 1'b0;
    logic                     reset_n;
    logic                     enable;
    i2c_request_t             request;
    logic [DIVIDER_WIDTH-1:0] divider;
    logic                     busy;
    logic [BYTE_WIDTH-1:0]    read_data;
    logic                     error;
    i2c_drive_t               dut_drive;
    i2c_drive_t               target_drive;
    i2c_sense_t               bus_sense;
    logic [ADDRESS_WIDTH-1:0] target_address;
    logic [15:0]              stretch_ticks;
    i2c_request_t             captured;
    logic                     stop_seen;

    string                 test_name;
    logic                  check_write;
    logic                  check_read;
    logic                  expected_error;
    i2c_request_t          expected_request;
    logic [BYTE_WIDTH-1:0] expected_read;
    logic [BYTE_WIDTH-1:0] written_register;
    logic [BYTE_WIDTH-1:0] written_data;
    logic [15:0]           lfsr;
    int                    cycle_count = 0;

    always #HALF_PERIOD clock = ~clock;

    // Wired-AND bus, either side pulls a line low
    assign bus_sense.scl = !(dut_drive.scl_low || target_drive.scl_low);
    assign bus_sense.sda = !(dut_drive.sda_low || target_drive.sda_low);

    i2c_master_top i_dut (
        .clock     (clock),
        .reset_n   (reset_n),
        .enable    (enable),
        .request   (request),
        .divider   (divider),
        .busy      (busy),
        .read_data (read_data),
        .error     (error),
        .bus_drive (dut_drive),
        .bus_sense (bus_sense)
    );

    i2c_target_model i_target (
        .clock          (clock),
        .reset_n        (reset_n),
        .device_address (target_address),
        .stretch_ticks  (stretch_ticks),
        .divider        (divider),
        .bus_sense      (bus_sense),
        .bus_drive      (target_drive),
        .captured       (captured),
        .stop_seen      (stop_seen)
    );

    ////////////////////
    // Helpers

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic random_write(output i2c_request_t req);
        logic [31:0] bits;
        req = '0;
        draw_bits(ADDRESS_WIDTH, bits);
        req.device_address = bits[ADDRESS_WIDTH-1:0];
        draw_bits(BYTE_WIDTH, bits);
        req.register_address = bits[BYTE_WIDTH-1:0];
        draw_bits(BYTE_WIDTH, bits);
        req.write_data = bits[BYTE_WIDTH-1:0];
    endtask

    task automatic start_request(input i2c_request_t req);
        @(negedge clock);
        request = req;
        enable  = 1'b1;
        @(negedge clock);
        enable = 1'b0;
    endtask

    task automatic wait_for_idle();
        while (!busy) @(negedge clock);
        while (busy) @(negedge clock);
        @(negedge clock);                                        // End-of-transfer checks sample here
    endtask

    ////////////////////
    // Checks

    assert property (@(posedge clock) disable iff (!reset_n)
        (stop_seen && check_write) |-> (captured == expected_request))
        else stop_on_failure($sformatf("ERROR %s: captured request expected %h actual %h",
            test_name, expected_request, captured));

    assert property (@(posedge clock) disable iff (!reset_n)
        $fell(busy) |-> (error == expected_error))
        else stop_on_failure($sformatf("ERROR %s: error expected %b actual %b",
            test_name, expected_error, error));

    assert property (@(posedge clock) disable iff (!reset_n)
        ($fell(busy) && check_read) |-> (read_data == expected_read))
        else stop_on_failure($sformatf("ERROR %s: read_data expected %h actual %h",
            test_name, expected_read, read_data));

    assert property (@(posedge clock) disable iff (!reset_n)
        !busy |-> (dut_drive == 2'b00))
        else stop_on_failure($sformatf("ERROR %s: idle bus_drive expected 00 actual %b",
            test_name, dut_drive));

    assert property (@(posedge clock) disable iff (!reset_n)
        (enable && !busy) |=> busy)
        else stop_on_failure($sformatf("%s: busy did not rise after an accepted request",
            test_name));

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            stop_on_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                CYCLE_LIMIT));
        end
    end

    ////////////////////
    // Stimulus

    initial begin
        i2c_request_t req;
        i2c_request_t second;
        logic [31:0]  bits;

        reset_n          = 1'b0;
        enable           = 1'b0;
        request          = '0;
        divider          = 16'd3;
        target_address   = '0;
        stretch_ticks    = '0;
        test_name        = "reset";
        check_write      = 1'b0;
        check_read       = 1'b0;
        expected_error   = 1'b0;
        expected_request = '0;
        expected_read    = '0;
        lfsr             = LFSR_SEED;
        repeat (RESET_CYCLES) @(negedge clock);
        reset_n = 1'b1;

        random_write(req);
        target_address   = req.device_address;
        test_name        = "random register write";
        expected_request = req;
        check_write      = 1'b1;
        start_request(req);
        wait_for_idle();
        check_write      = 1'b0;
        written_register = req.register_address;
        written_data     = req.write_data;

        test_name       = "read back written register";
        req.read_write  = 1'b1;
        expected_read   = written_data;
        check_read      = 1'b1;
        start_request(req);
        wait_for_idle();

        draw_bits(BYTE_WIDTH, bits);
        req.register_address = bits[BYTE_WIDTH-1:0];
        if (req.register_address == written_register) req.register_address = ~written_register;
        test_name     = "read unwritten register";
        expected_read = req.register_address ^ 8'hA5;
        start_request(req);
        wait_for_idle();
        check_read = 1'b0;

        draw_bits(ADDRESS_WIDTH, bits);
        req.device_address = bits[ADDRESS_WIDTH-1:0];
        if (req.device_address == target_address) req.device_address = target_address ^ 7'h01;
        req.read_write = 1'b0;
        test_name      = "address not acknowledged";
        expected_error = 1'b1;
        start_request(req);
        wait_for_idle();

        req            = '{1'b1, target_address, written_register, 8'h00};
        test_name      = "clock stretch within limit";
        stretch_ticks  = 16'd50;
        expected_error = 1'b0;
        expected_read  = written_data;
        check_read     = 1'b1;
        start_request(req);
        wait_for_idle();
        check_read = 1'b0;

        random_write(req);
        req.device_address = target_address;
        test_name          = "clock stretch timeout";
        stretch_ticks      = 16'd400;
        expected_error     = 1'b1;
        start_request(req);
        wait_for_idle();
        stretch_ticks = '0;
        while (!bus_sense.scl) @(negedge clock);               // Target still holds SCL

        random_write(req);
        req.device_address      = target_address;
        second                  = req;
        second.register_address = ~req.register_address;
        second.write_data       = ~req.write_data;
        test_name               = "enable while busy";
        expected_error          = 1'b0;
        expected_request        = req;
        check_write             = 1'b1;
        start_request(req);
        @(negedge clock);
        request = second;                                        // Must be ignored
        enable  = 1'b1;
        @(negedge clock);
        enable = 1'b0;
        wait_for_idle();
        check_write = 1'b0;

        $display("Test completed successfully");
        $finish;
    end

endmodule
